// ==== bench/tb_rv_asm.svh ====
`ifndef TB_RV_ASM_SVH
`define TB_RV_ASM_SVH

// Each encoder fills one view of the instruction union
function automatic word_t r_format(logic [6:0] funct7, logic [2:0] funct3,
                                   logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    instr_u w;
    w.r = '{funct7, rs2, rs1, funct3, rd, OP_REG};
    return w;
endfunction

function automatic word_t i_format(logic [11:0] imm, logic [4:0] rs1, logic [2:0] funct3,
                                   logic [4:0] rd, logic [6:0] opcode);
    instr_u w;
    w.i = '{imm, rs1, funct3, rd, opcode};
    return w;
endfunction

function automatic word_t s_format(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    instr_u w;
    w.s = '{imm[11:5], rs2, rs1, 3'd2, imm[4:0], OP_STORE};  // sw only
    return w;
endfunction

function automatic word_t b_format(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] funct3);
    instr_u w;
    w.b = '{imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], OP_BRANCH};
    return w;
endfunction

function automatic word_t u_format(logic [19:0] imm, logic [4:0] rd);
    instr_u w;
    w.u = '{imm, rd, OP_LUI};
    return w;
endfunction

function automatic word_t j_format(logic [20:0] imm, logic [4:0] rd);
    instr_u w;
    w.j = '{imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    return w;
endfunction

// Writes one word per cycle, reset must already be high
task automatic load_program(input word_t words[$]);
    foreach (words[i]) begin
        load_en   = 1'b1;
        load_addr = word_t'(i * 4);
        load_data = words[i];
        @(posedge clk);
        #1;
    end
    load_en = 1'b0;
endtask

`endif

// ==== bench/tb_rv_multicycle.sv ====
`timescale 1ns/1ps

module tb_rv_multicycle import rv_pkg::*; ();
    localparam word_t DATA_BASE = 32'h0000_0400;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_s;

    logic   clk;
    logic   reset;
    logic   load_en;
    word_t  load_addr;
    word_t  load_data;
    logic   store_valid;
    word_t  store_addr;
    word_t  store_data;
    logic   halted;
    word_t  prog[$];
    store_s expected[$];
    store_s seen[$];
    int     mismatch_errs = 0;
    int     other_errs = 0;
    int     budget = 64;
    int     cycles = 0;

    rv_multicycle_top #(.MEM_WORDS(1024), .RESET_PC(32'h0000_0000)) UUT (
        .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .store_valid(store_valid), .store_addr(store_addr),
        .store_data(store_data), .halted(halted)
    );

    `include "tb_rv_asm.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Each run raises the budget before it starts, so a hung run runs out of it
    initial begin
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the DUT did not halt within %0d cycles", cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    always @(posedge clk) begin
        if (!reset && store_valid) begin
            seen.push_back('{store_addr, store_data});
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic start_program();
        prog.delete();
        expected.delete();
        prog.push_back(i_format(DATA_BASE[11:0], 5'd0, 3'd0, 5'd31, OP_IMM));  // x31 = data base
    endtask

    task automatic load_const(logic [4:0] rd, word_t value);
        word_t upper;
        upper = value + 32'h800;  // Rounds up when the addi part is negative
        prog.push_back(u_format(upper[31:12], rd));
        prog.push_back(i_format(value[11:0], rd, 3'd0, rd, OP_IMM));
    endtask

    task automatic store_only(logic [4:0] rs, int k);
        prog.push_back(s_format(12'(4 * k), rs, 5'd31));
    endtask

    task automatic store_expect(logic [4:0] rs, int k, word_t value);
        store_only(rs, k);
        expected.push_back('{DATA_BASE + word_t'(4 * k), value});
    endtask

    // Operands sit in x1 and x2, the result goes through x3
    task automatic r_case(logic [6:0] funct7, logic [2:0] funct3, int k, word_t value);
        prog.push_back(r_format(funct7, funct3, 5'd3, 5'd1, 5'd2));
        store_expect(5'd3, k, value);
    endtask

    task automatic i_case(logic [4:0] rs1, logic [2:0] funct3, logic [11:0] imm, int k,
                          word_t value);
        prog.push_back(i_format(imm, rs1, funct3, 5'd3, OP_IMM));
        store_expect(5'd3, k, value);
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected data %08h, actual %08h", name, exp, act);
            mismatch_errs++;
        end
    endtask

    task automatic check_addr(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected address %08h, actual %08h", name, exp, act);
            mismatch_errs++;
        end
    endtask

    task automatic compare_store_log(string name);
        if (seen.size() != expected.size()) begin
            $display("%s: expected %0d stores but the DUT made %0d", name, expected.size(),
                     seen.size());
            other_errs++;
        end
        for (int i = 0; i < expected.size() && i < seen.size(); i++) begin
            check_addr($sformatf("%s store %0d", name, i), expected[i].addr, seen[i].addr);
            check_word($sformatf("%s store %0d", name, i), expected[i].data, seen[i].data);
        end
    endtask

    task automatic run_program(string name);
        prog.push_back(i_format(12'd0, 5'd0, 3'd0, 5'd0, OP_SYSTEM));  // ecall ends every program
        budget += prog.size() * 5 + prog.size() + 16;  // Load, execute and reset cycles
        seen.delete();
        reset = 1'b1;
        step();
        load_program(prog);
        repeat (2) begin
            step();
            if (halted !== 1'b0 || store_valid !== 1'b0) begin
                $display("%s: halted or store_valid is not low during reset", name);
                other_errs++;
            end
        end
        reset = 1'b0;
        while (halted !== 1'b1) begin
            step();
        end
        compare_store_log(name);
    endtask

    task automatic reset_then_ecall();
        prog.delete();
        expected.delete();
        run_program("reset_ecall");
    endtask

    task automatic register_ops();
        word_t a;
        word_t b;
        a = 32'hF00F_1234;
        b = 32'h0000_0013;
        start_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        r_case(7'h00, 3'd0, 0, a + b);
        r_case(7'h20, 3'd0, 1, a - b);
        r_case(7'h00, 3'd7, 2, a & b);
        r_case(7'h00, 3'd6, 3, a | b);
        r_case(7'h00, 3'd4, 4, a ^ b);
        r_case(7'h00, 3'd2, 5, {31'd0, $signed(a) < $signed(b)});
        r_case(7'h00, 3'd3, 6, {31'd0, a < b});
        r_case(7'h00, 3'd1, 7, a << b[4:0]);
        r_case(7'h00, 3'd5, 8, a >> b[4:0]);
        r_case(7'h20, 3'd5, 9, 32'hFFFF_FE01);  // a >> 19 with the top 19 bits copying the sign
        run_program("register_ops");
    endtask

    task automatic immediate_ops();
        word_t a;
        a = 32'h1234_5678;
        start_program();
        load_const(5'd1, a);
        load_const(5'd2, 32'hFFFF_FF00);
        i_case(5'd1, 3'd0, 12'hFFB, 0, a + 32'hFFFF_FFFB);  // addi -5
        i_case(5'd1, 3'd0, 12'h07F, 1, a + 32'h0000_007F);
        i_case(5'd1, 3'd7, 12'hF0F, 2, a & 32'hFFFF_FF0F);
        i_case(5'd1, 3'd6, 12'h800, 3, a | 32'hFFFF_F800);  // ori -2048
        i_case(5'd2, 3'd6, 12'h0F0, 4, 32'hFFFF_FFF0);
        i_case(5'd1, 3'd4, 12'hFFF, 5, ~a);
        i_case(5'd2, 3'd2, 12'hFFF, 6, 32'd1);  // -256 < -1
        i_case(5'd2, 3'd2, 12'hE00, 7, 32'd0);  // -256 < -512 is false
        i_case(5'd1, 3'd2, 12'hFFF, 8, 32'd0);
        prog.push_back(u_format(20'hABCDE, 5'd4));
        store_expect(5'd4, 9, 32'hABCD_E000);
        run_program("immediate_ops");
    endtask

    task automatic load_store_roundtrip();
        start_program();
        load_const(5'd5, 32'hDEAD_BEEF);
        load_const(5'd6, 32'h0BAD_F00D);
        store_expect(5'd5, 0, 32'hDEAD_BEEF);
        store_expect(5'd6, 1, 32'h0BAD_F00D);
        prog.push_back(i_format(12'd0, 5'd31, 3'd2, 5'd7, OP_LOAD));
        prog.push_back(i_format(12'd4, 5'd31, 3'd2, 5'd8, OP_LOAD));
        store_expect(5'd7, 2, 32'hDEAD_BEEF);
        store_expect(5'd8, 3, 32'h0BAD_F00D);
        run_program("load_store");
    endtask

    task automatic branches_and_jal();
        word_t link;
        start_program();
        load_const(5'd1, 32'd7);
        load_const(5'd2, 32'd7);
        load_const(5'd3, 32'd9);
        prog.push_back(b_format(13'd8, 5'd2, 5'd1, 3'd0));  // beq taken
        store_only(5'd3, 0);
        store_expect(5'd1, 1, 32'd7);
        prog.push_back(b_format(13'd8, 5'd3, 5'd1, 3'd0));  // beq not taken
        store_expect(5'd3, 2, 32'd9);
        prog.push_back(b_format(13'd8, 5'd3, 5'd1, 3'd1));  // bne taken
        store_only(5'd2, 3);
        store_expect(5'd2, 4, 32'd7);
        prog.push_back(b_format(13'd8, 5'd2, 5'd1, 3'd1));  // bne not taken
        store_expect(5'd3, 5, 32'd9);
        link = word_t'(prog.size() * 4 + 4);  // Program starts at address zero
        prog.push_back(j_format(21'd8, 5'd9));
        store_only(5'd1, 6);
        store_expect(5'd9, 7, link);
        run_program("branches_jal");
    endtask

    task automatic random_operands();
        word_t a;
        word_t b;
        for (int r = 0; r < 20; r++) begin
            a = $urandom;
            b = $urandom;
            start_program();
            load_const(5'd1, a);
            load_const(5'd2, b);
            r_case(7'h00, 3'd0, 0, a + b);
            r_case(7'h20, 3'd0, 1, a - b);
            r_case(7'h00, 3'd4, 2, a ^ b);
            r_case(7'h00, 3'd2, 3, {31'd0, $signed(a) < $signed(b)});
            r_case(7'h00, 3'd3, 4, {31'd0, a < b});
            run_program($sformatf("random_%0d", r));
        end
    endtask

    initial begin
        reset     = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(32'h1c50));
        reset_then_ecall();
        register_ops();
        immediate_ops();
        load_store_roundtrip();
        branches_and_jal();
        random_operands();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        if (mismatch_errs + other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
logic/rv_pkg.sv
logic/regfile.sv
logic/alu.sv
logic/extend.sv
logic/datapath_multicycle.sv
logic/control_fsm.sv
logic/unified_memory.sv
logic/rv_multicycle_top.sv
+incdir+bench
bench/tb_rv_multicycle.sv

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  word_t      a,
    input  word_t      b,
    input  alu_op_e    op,
    output word_t      y,
    output alu_flags_s flags
);
    logic  sub;
    word_t b_eff;
    word_t sum;
    logic  carry;
    logic  overflow;

    // SUB and both compares go through the subtract path
    assign sub   = (op == ALU_SUB) || (op == ALU_SLT) || (op == ALU_SLTU);
    assign b_eff = sub ? ~b : b;
    assign {carry, sum} = {1'b0, a} + {1'b0, b_eff} + {32'd0, sub};

    assign overflow = (a[31] == b_eff[31]) && (sum[31] != a[31]);

    always_comb begin
        case (op)
            ALU_ADD:    y = sum;
            ALU_SUB:    y = sum;
            ALU_AND:    y = a & b;
            ALU_OR:     y = a | b;
            ALU_XOR:    y = a ^ b;
            ALU_SLT:    y = {31'd0, sum[31] ^ overflow};  // Sign corrected for overflow
            ALU_SLTU:   y = {31'd0, ~carry};              // No carry out means a borrow
            ALU_SLL:    y = a << b[4:0];
            ALU_SRL:    y = a >> b[4:0];
            ALU_SRA:    y = word_t'($signed(a) >>> b[4:0]);
            ALU_PASS_B: y = b;
            default:    y = '0;
        endcase
    end

    assign flags.zero     = (y == '0);
    assign flags.negative = y[31];
    assign flags.carry    = carry;
    assign flags.overflow = overflow;

endmodule

// ==== logic/control_fsm.sv ====
`timescale 1ns/1ps

module control_fsm import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  instr_u     instr,
    input  alu_flags_s alu_flags,
    output dp_ctrl_s   ctrl,
    output logic       mem_we,
    output logic       halted
);
    typedef enum logic [3:0] {
        S_FETCH, S_DECODE, S_EXEC, S_ALU_WB, S_MEM_ADDR, S_MEM_READ,
        S_MEM_WB, S_MEM_WRITE, S_BRANCH, S_JAL, S_LUI, S_HALT
    } state_e;

    state_e     state;
    state_e     state_next;
    logic [6:0] opcode;
    alu_op_e    alu_dec;
    logic       rd_nonzero;
    logic       take_branch;

    assign opcode      = instr.r.opcode;
    assign rd_nonzero  = (instr.r.rd != 5'd0);
    assign take_branch = instr.b.funct3[0] ? !alu_flags.zero : alu_flags.zero;  // bne : beq

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (instr.r.funct3)
            3'd0:    alu_dec = (opcode == OP_REG && instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'd1:    alu_dec = ALU_SLL;
            3'd2:    alu_dec = ALU_SLT;
            3'd3:    alu_dec = ALU_SLTU;
            3'd4:    alu_dec = ALU_XOR;
            3'd5:    alu_dec = instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
            3'd6:    alu_dec = ALU_OR;
            default: alu_dec = ALU_AND;
        endcase
    end

    always_comb begin
        state_next = S_FETCH;
        case (state)
            S_DECODE: begin
                case (opcode)
                    OP_REG, OP_IMM:    state_next = S_EXEC;
                    OP_LOAD, OP_STORE: state_next = S_MEM_ADDR;
                    OP_BRANCH:         state_next = S_BRANCH;
                    OP_JAL:            state_next = S_JAL;
                    OP_LUI:            state_next = S_LUI;
                    default:           state_next = S_HALT;  // ecall and unknown opcodes
                endcase
            end
            S_FETCH:    state_next = S_DECODE;
            S_EXEC:     state_next = S_ALU_WB;
            S_JAL:      state_next = S_ALU_WB;
            S_MEM_ADDR: state_next = (opcode == OP_STORE) ? S_MEM_WRITE : S_MEM_READ;
            S_MEM_READ: state_next = S_MEM_WB;
            S_HALT:     state_next = S_HALT;
            default:    state_next = S_FETCH;
        endcase
    end

    always_comb begin
        ctrl = '{rf_we: 1'b0, imm_src: IMM_I, alu_ctrl: ALU_ADD, alu_src_a: ALU_SRC_REG_1,
                 alu_src_b: ALU_SRC_REG_2, res_src: RES_SRC_ALU_OUT, addr_src: 1'b0,
                 en_ir: 1'b0, en_npc: 1'b0, en_oldpc: 1'b0, rf_wd_src: 1'b0};
        case (state)
            S_FETCH: begin
                ctrl.alu_src_a = ALU_SRC_PC;
                ctrl.alu_src_b = ALU_SRC_4;
                ctrl.res_src   = RES_SRC_ALU_NOW;
                ctrl.en_ir     = 1'b1;
                ctrl.en_npc    = 1'b1;
                ctrl.en_oldpc  = 1'b1;
            end
            S_DECODE: begin
                ctrl.imm_src   = (opcode == OP_JAL) ? IMM_J : IMM_B;  // Branch or jump target
                ctrl.alu_src_a = ALU_SRC_PC_OLD;
                ctrl.alu_src_b = ALU_SRC_EXT_IMM;
            end
            S_EXEC: begin
                ctrl.alu_ctrl  = alu_dec;
                ctrl.alu_src_b = (opcode == OP_IMM) ? ALU_SRC_EXT_IMM : ALU_SRC_REG_2;
            end
            S_MEM_ADDR: begin
                ctrl.imm_src   = (opcode == OP_STORE) ? IMM_S : IMM_I;
                ctrl.alu_src_b = ALU_SRC_EXT_IMM;
            end
            S_MEM_READ, S_MEM_WRITE: ctrl.addr_src = 1'b1;
            S_MEM_WB: begin
                ctrl.res_src = RES_SRC_MEM;
                ctrl.rf_we   = rd_nonzero;
            end
            S_ALU_WB: ctrl.rf_we = rd_nonzero;
            S_BRANCH: begin
                ctrl.alu_ctrl = ALU_SUB;
                ctrl.en_npc   = take_branch;
            end
            S_JAL: begin
                ctrl.alu_src_a = ALU_SRC_PC_OLD;  // Link value, written back in ALU_WB
                ctrl.alu_src_b = ALU_SRC_4;
                ctrl.en_npc    = 1'b1;
            end
            S_LUI: begin
                ctrl.imm_src   = IMM_U;
                ctrl.alu_ctrl  = ALU_PASS_B;
                ctrl.alu_src_b = ALU_SRC_EXT_IMM;
                ctrl.res_src   = RES_SRC_ALU_NOW;
                ctrl.rf_we     = rd_nonzero;
            end
            default: ;
        endcase
    end

    assign mem_we = (state == S_MEM_WRITE);
    assign halted = (state == S_HALT);

    a_state_legal: assert property (@(posedge clk) disable iff (reset) state <= S_HALT)
        else $error("control_fsm: illegal state encoding");

    // Only a decoded sw may write memory, and only right after its address cycle
    a_store_sequence: assert property (
        @(posedge clk) disable iff (reset)
            mem_we |-> (opcode == OP_STORE && $past(state) == S_MEM_ADDR)
    ) else $error("control_fsm: mem_we outside the store sequence");

endmodule

// ==== logic/datapath_multicycle.sv ====
`timescale 1ns/1ps

module datapath_multicycle import rv_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic       clk,
    input  logic       reset,
    input  word_t      m_rd,
    input  dp_ctrl_s   ctrl,
    output word_t      m_addr,
    output word_t      m_wd,
    output alu_flags_s alu_flags,
    output instr_u     instr
);
    word_t pc;
    word_t pc_old;
    word_t m_rd_r;
    word_t rd1;
    word_t rd2;
    word_t reg_rd1;
    word_t reg_rd2;
    word_t reg_wd;
    word_t ext_imm;
    word_t alu_a;
    word_t alu_b;
    word_t alu_out;
    word_t alu_out_r;
    word_t result;

    always_comb begin
        case (ctrl.res_src)
            RES_SRC_ALU_OUT: result = alu_out_r;
            RES_SRC_MEM:     result = m_rd_r;
            RES_SRC_ALU_NOW: result = alu_out;  // Lets FETCH write PC+4 in the same cycle
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= RESET_PC;
            pc_old <= RESET_PC;
            instr  <= '0;
        end else begin
            if (ctrl.en_npc) begin
                pc <= result;
            end
            if (ctrl.en_oldpc) begin
                pc_old <= pc;  // Keeps the address of the instruction being run
            end
            if (ctrl.en_ir) begin
                instr <= m_rd;
            end
        end
    end

    // Payload registers follow their sources every cycle
    always_ff @(posedge clk) begin
        m_rd_r    <= m_rd;
        rd1       <= reg_rd1;
        rd2       <= reg_rd2;
        alu_out_r <= alu_out;
    end

    assign m_addr = ctrl.addr_src ? result : pc;
    assign m_wd   = rd2;
    assign reg_wd = ctrl.rf_wd_src ? pc : result;

    regfile rf (
        .clk   (clk),
        .reset (reset),
        .ra1   (instr.r.rs1),
        .ra2   (instr.r.rs2),
        .wa    (instr.r.rd),
        .wd    (reg_wd),
        .we    (ctrl.rf_we),
        .rd1   (reg_rd1),
        .rd2   (reg_rd2)
    );

    extend ext (
        .instr   (instr),
        .imm_src (ctrl.imm_src),
        .imm     (ext_imm)
    );

    function automatic word_t pick_operand(alu_src_e sel);
        case (sel)
            ALU_SRC_REG_1:   return rd1;
            ALU_SRC_REG_2:   return rd2;
            ALU_SRC_EXT_IMM: return ext_imm;
            ALU_SRC_PC:      return pc;
            ALU_SRC_PC_OLD:  return pc_old;
            ALU_SRC_4:       return 32'd4;
            default:         return '0;
        endcase
    endfunction

    always_comb begin
        alu_a = pick_operand(ctrl.alu_src_a);
        alu_b = pick_operand(ctrl.alu_src_b);
    end

    alu alu0 (
        .a     (alu_a),
        .b     (alu_b),
        .op    (ctrl.alu_ctrl),
        .y     (alu_out),
        .flags (alu_flags)
    );

    // A registered ALU result consumed now must have come from valid operands
    a_operands_valid: assert property (
        @(posedge clk) disable iff (reset)
            (ctrl.res_src == RES_SRC_ALU_OUT && (ctrl.en_npc || ctrl.rf_we))
            |-> $past(ctrl.alu_src_a <= ALU_SRC_4 && ctrl.alu_src_b <= ALU_SRC_4)
    ) else $error("datapath: registered ALU result built from invalid operand select");

endmodule

// ==== logic/extend.sv ====
`timescale 1ns/1ps

module extend import rv_pkg::*; (
    input  instr_u   instr,
    input  imm_src_e imm_src,
    output word_t    imm
);

    always_comb begin
        case (imm_src)
            IMM_I: begin
                imm = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0};
            end
            IMM_S: begin
                imm = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
            end
            IMM_B: begin
                imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            end
            IMM_U: begin
                imm = {instr.u.imm31_12, 12'd0};  // Upper immediate, low bits cleared
            end
            IMM_J: begin
                imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                       instr.j.imm11, instr.j.imm10_1, 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/1ps

module regfile import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [4:0] ra1,
    input  logic [4:0] ra2,
    input  logic [4:0] wa,
    input  word_t      wd,
    input  logic       we,
    output word_t      rd1,
    output word_t      rd2
);
    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];  // x0 is hardwired to zero
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

    // The controller drops write enables for rd = x0, so a nonzero value never gets here
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (reset)
            (we && wa == 5'd0) |-> (wd == '0)
    ) else $error("regfile: nonzero write to x0");

endmodule

// ==== logic/rv_multicycle_top.sv ====
`timescale 1ns/1ps

module rv_multicycle_top import rv_pkg::*; #(
    parameter int    MEM_WORDS = 1024,
    parameter word_t RESET_PC  = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  load_en,
    input  word_t load_addr,
    input  word_t load_data,
    output logic  store_valid,
    output word_t store_addr,
    output word_t store_data,
    output logic  halted
);
    dp_ctrl_s   ctrl;
    alu_flags_s alu_flags;
    instr_u     instr;
    word_t      m_addr;
    word_t      m_wd;
    word_t      m_rd;
    logic       mem_we;

    control_fsm ctl (
        .clk(clk), .reset(reset), .instr(instr), .alu_flags(alu_flags),
        .ctrl(ctrl), .mem_we(mem_we), .halted(halted)
    );

    datapath_multicycle #(.RESET_PC(RESET_PC)) dp (
        .clk(clk), .reset(reset), .m_rd(m_rd), .ctrl(ctrl),
        .m_addr(m_addr), .m_wd(m_wd), .alu_flags(alu_flags), .instr(instr)
    );

    unified_memory #(.MEM_WORDS(MEM_WORDS)) mem (
        .clk(clk), .reset(reset), .addr(m_addr), .wd(m_wd), .we(mem_we), .rd(m_rd),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data)
    );

    // Store monitor mirrors the memory write port
    assign store_valid = mem_we;
    assign store_addr  = m_addr;
    assign store_data  = m_wd;

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } s_fmt_s;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_s;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_s;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_s;

    // Every view covers the same 32 instruction bits
    typedef union packed {
        r_fmt_s r;
        i_fmt_s i;
        s_fmt_s s;
        b_fmt_s b;
        u_fmt_s u;
        j_fmt_s j;
    } instr_u;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_src_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        ALU_SRC_REG_1, ALU_SRC_REG_2, ALU_SRC_EXT_IMM,
        ALU_SRC_PC, ALU_SRC_PC_OLD, ALU_SRC_4
    } alu_src_e;

    typedef enum logic [1:0] {RES_SRC_ALU_OUT, RES_SRC_MEM, RES_SRC_ALU_NOW} res_src_e;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } alu_flags_s;

    typedef struct packed {
        logic     rf_we;
        imm_src_e imm_src;
        alu_op_e  alu_ctrl;
        alu_src_e alu_src_a;
        alu_src_e alu_src_b;
        res_src_e res_src;
        logic     addr_src;   // 0 selects the PC, 1 the result bus
        logic     en_ir;
        logic     en_npc;
        logic     en_oldpc;
        logic     rf_wd_src;  // 1 writes the PC instead of the result
    } dp_ctrl_s;

endpackage

// ==== logic/unified_memory.sv ====
`timescale 1ns/1ps

module unified_memory import rv_pkg::*; #(
    parameter int MEM_WORDS = 1024
) (
    input  logic  clk,
    input  logic  reset,
    input  word_t addr,
    input  word_t wd,
    input  logic  we,
    output word_t rd,
    input  logic  load_en,
    input  word_t load_addr,
    input  word_t load_data
);
    localparam int AW = $clog2(MEM_WORDS);

    word_t mem [MEM_WORDS];

    assign rd = mem[addr[AW+1:2]];  // Byte address, word granular

    always_ff @(posedge clk) begin
        if (reset) begin
            if (load_en) begin
                mem[load_addr[AW+1:2]] <= load_data;  // Program load only while in reset
            end
        end else if (we) begin
            mem[addr[AW+1:2]] <= wd;
        end
    end

    a_store_addr: assert property (
        @(posedge clk) disable iff (reset)
            we |-> (addr[1:0] == 2'b00 && addr < word_t'(MEM_WORDS * 4))
    ) else $error("unified_memory: store to 0x%08h is unaligned or out of range", addr);

endmodule
